// File: verilog/dma_path_pkg.sv
package dma_path_pkg;

	////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////
	localparam int beat_w       = 128;   // one fpu beat
	localparam int cmd_w        = 72;    // {length, dram addr, dpram addr}
	localparam int dram_addr_w  = 40;
	localparam int dpram_addr_w = 16;
	localparam int len_w        = 16;

	// header field positions, command words use the same layout
	localparam int form_lsb  = 72;
	localparam int form_msb  = 79;
	localparam int len_lsb   = 56;
	localparam int len_msb   = 71;
	localparam int dram_lsb  = 16;
	localparam int dram_msb  = 55;
	localparam int owner_lsb = 14;   // owner sits in dpram addr 15:14

	localparam int num_ports = 4;    // requesters a to d
	localparam int owner_w   = 2;

	// buffer depths
	localparam int ingress_depth = 256;
	localparam int cmd_depth     = 32;
	localparam int wdata_depth   = 256;

	////////////////////////////////////////////////////////////
	// opcodes and states
	////////////////////////////////////////////////////////////
	typedef enum logic [7:0] {
		msg_read  = 8'h01,
		msg_write = 8'h03
	} msg_form_e;

	typedef enum logic [1:0] {arb_scan, arb_header, arb_payload, arb_release} arb_state_e;

	typedef enum logic [1:0] {disp_idle, disp_decode, disp_read_out, disp_write_move} disp_state_e;

	typedef enum logic {wr_idle, wr_stream} wr_state_e;

endpackage

// File: verilog/dma_path_if.sv
`timescale 1ns/10ps

// beats from the token arbiter into the ingress buffer
interface ingress_if import dma_path_pkg::*; ();
	logic                  beat_valid;
	logic [beat_w-1:0]     beat_data;
	logic [owner_w-1:0]    beat_owner;   // granted requester
	logic                  beat_first;   // header beat
	logic                  space;        // ingress buffer not full

	modport source (output beat_valid, beat_data, beat_owner, beat_first, input space);
	modport sink (input beat_valid, beat_data, beat_owner, beat_first, output space);
endinterface

// commands and payload from the dispatcher into the write engine
interface write_path_if import dma_path_pkg::*; ();
	logic                cmd_push;
	logic [cmd_w-1:0]    cmd;
	logic                data_push;
	logic [beat_w-1:0]   data;
	logic                cmd_full;
	logic                data_full;

	modport producer (
		output cmd_push, cmd, data_push, data,
		input  cmd_full, data_full
	);
	modport consumer (
		input  cmd_push, cmd, data_push, data,
		output cmd_full, data_full
	);
endinterface

// File: verilog/sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo #(
	parameter int width = 8,
	parameter int depth = 16     // power of two
) (
	input  logic             fpu_clk,
	input  logic             reset,
	input  logic             push,
	input  logic [width-1:0] wdata,
	input  logic             pop,
	output logic [width-1:0] rdata,
	output logic             full,
	output logic             empty
);

	logic [width-1:0]         mem [depth];
	logic [$clog2(depth)-1:0] wr_ptr;
	logic [$clog2(depth)-1:0] rd_ptr;
	logic [$clog2(depth):0]   count;
	logic                     wr_en;
	logic                     rd_en;

	assign wr_en = push && !full;    // push on full is dropped
	assign rd_en = pop && !empty;
	assign full  = (count == depth);
	assign empty = (count == 0);
	assign rdata = mem[rd_ptr];      // head shows without a pop

	always_ff @(posedge fpu_clk) begin
		if (wr_en)
			mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: verilog/fpu_token_arbiter.sv
`timescale 1ns/10ps

module fpu_token_arbiter import dma_path_pkg::*; (
	input  logic                 fpu_clk,
	input  logic                 reset,
	input  logic [num_ports-1:0] dma_req,
	input  logic [num_ports-1:0] dma_write_valid,
	input  logic [beat_w-1:0]    dma_write_data [num_ports],
	output logic [num_ports-1:0] dma_resp,
	output logic [num_ports-1:0] dma_write_ready,
	ingress_if.source            ingress
);

	arb_state_e           state;
	logic [num_ports-1:0] grant;        // one-hot token
	logic [owner_w-1:0]   owner;
	logic [owner_w-1:0]   last_owner;
	logic [owner_w-1:0]   pick;
	logic [owner_w-1:0]   idx;
	logic                 pick_found;
	logic                 resp_r;
	logic                 resp_sent;
	logic                 open_win;     // beats accepted from the owner
	logic                 beat_hs;
	msg_form_e            hdr_form;
	logic [len_w-1:0]     hdr_len;
	logic [len_w-1:0]     beat_len;
	logic [len_w-1:0]     beat_cnt;

	////////////////////////////////////////////////////////////
	// round-robin scan, starts after the last owner
	////////////////////////////////////////////////////////////
	always_comb begin
		pick       = last_owner;
		pick_found = 1'b0;
		idx        = last_owner;
		for (int i = 1; i <= num_ports; i++) begin
			idx = owner_w'(last_owner + i);
			if (!pick_found && dma_req[idx]) begin
				pick       = idx;
				pick_found = 1'b1;
			end
		end
	end

	// owner steering
	always_comb begin
		open_win = (state == arb_payload) || (state == arb_header && resp_sent);
		beat_hs  = open_win && dma_write_valid[owner] && ingress.space;
		hdr_form = msg_form_e'(dma_write_data[owner][form_msb:form_lsb]);
		hdr_len  = dma_write_data[owner][len_msb:len_lsb];
	end

	assign ingress.beat_valid = open_win && dma_write_valid[owner];
	assign ingress.beat_data  = dma_write_data[owner];
	assign ingress.beat_owner = owner;
	assign ingress.beat_first = (state == arb_header);

	assign dma_resp        = resp_r ? grant : '0;
	assign dma_write_ready = (open_win && ingress.space) ? grant : '0;

	////////////////////////////////////////////////////////////
	// token FSM with beat counting
	////////////////////////////////////////////////////////////
	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			state      <= arb_scan;
			grant      <= '0;
			owner      <= '0;
			last_owner <= owner_w'(num_ports - 1);   // first scan starts at a
			resp_r     <= 1'b0;
			resp_sent  <= 1'b0;
			beat_len   <= '0;
			beat_cnt   <= '0;
		end else begin
			resp_r <= 1'b0;
			case (state)
				arb_scan: begin
					if (pick_found) begin
						grant     <= {{(num_ports-1){1'b0}}, 1'b1} << pick;
						owner     <= pick;
						resp_sent <= 1'b0;
						state     <= arb_header;
					end
				end
				arb_header: begin
					if (!resp_sent) begin
						resp_r    <= 1'b1;   // single pulse after grant
						resp_sent <= 1'b1;
					end
					if (beat_hs) begin
						beat_len <= hdr_len;
						beat_cnt <= 16'd1;
						if (hdr_form == msg_write && hdr_len > 16'd1) begin
							state <= arb_payload;
						end else begin
							grant <= '0;         // read is header only
							state <= arb_release;
						end
					end
				end
				arb_payload: begin
					if (beat_hs) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (beat_cnt + 1'b1 >= beat_len) begin
							grant <= '0;
							state <= arb_release;
						end
					end
				end
				arb_release: begin
					last_owner <= owner;
					state      <= arb_scan;
				end
				default: state <= arb_scan;
			endcase
		end
	end

endmodule

// File: verilog/dma_command_dispatcher.sv
`timescale 1ns/10ps

module dma_command_dispatcher import dma_path_pkg::*; (
	input  logic                    fpu_clk,
	input  logic                    reset,
	ingress_if.sink                 ingress,
	write_path_if.producer          wpath,
	output logic [dram_addr_w-1:0]  rcc_dram_addr,
	output logic [dpram_addr_w-1:0] rcc_dpram_addr,
	output logic [len_w-1:0]        rcc_length,
	output logic                    rcc_valid,
	input  logic                    rcc_ready
);

	disp_state_e               state;
	logic                      in_push;
	logic                      in_pop;
	logic                      in_full;
	logic                      in_empty;
	logic [beat_w+owner_w-1:0] in_wdata;
	logic [beat_w+owner_w-1:0] in_rdata;
	logic [owner_w-1:0]        tag_owner;
	logic [owner_w-1:0]        stamp_owner;
	logic [form_msb:0]         hdr_q;
	logic [owner_w-1:0]        hdr_owner;
	logic [len_w-1:0]          hdr_len;
	logic [cmd_w-1:0]          cmd_q;
	logic [len_w-1:0]          pay_len;
	logic [len_w-1:0]          move_cnt;
	logic                      cmd_sent;
	logic                      cmd_push_w;
	logic                      data_move;

	// payload beats carry the owner of their header
	assign stamp_owner   = ingress.beat_first ? ingress.beat_owner : tag_owner;
	assign in_wdata      = {stamp_owner, ingress.beat_data};
	assign in_push       = ingress.beat_valid && !in_full;
	assign ingress.space = !in_full;

	sync_fifo #(.width(beat_w + owner_w), .depth(ingress_depth)) ingress_fifo (
		.fpu_clk (fpu_clk),
		.reset   (reset),
		.push    (in_push),
		.wdata   (in_wdata),
		.pop     (in_pop),
		.rdata   (in_rdata),
		.full    (in_full),
		.empty   (in_empty)
	);

	assign hdr_len    = hdr_q[len_msb:len_lsb];
	assign cmd_push_w = (state == disp_write_move) && !cmd_sent && !wpath.cmd_full;
	assign data_move  = (state == disp_write_move) && (move_cnt != pay_len) &&
	                    !in_empty && !wpath.data_full;
	assign in_pop     = (state == disp_idle && !in_empty) || data_move;

	assign wpath.cmd_push  = cmd_push_w;
	assign wpath.cmd       = cmd_q;
	assign wpath.data_push = data_move;
	assign wpath.data      = in_rdata[beat_w-1:0];

	assign rcc_valid      = (state == disp_read_out);   // held until rcc_ready
	assign rcc_length     = cmd_q[len_msb:len_lsb];
	assign rcc_dram_addr  = cmd_q[dram_msb:dram_lsb];
	assign rcc_dpram_addr = cmd_q[dpram_addr_w-1:0];

	always_ff @(posedge fpu_clk) begin
		if (in_push && ingress.beat_first)
			tag_owner <= ingress.beat_owner;
		if (state == disp_idle && !in_empty) begin
			hdr_q     <= in_rdata[form_msb:0];
			hdr_owner <= in_rdata[beat_w +: owner_w];
		end
		// owner into dpram 15:14, bits 13:12 cleared
		if (state == disp_decode)
			cmd_q <= {hdr_len, hdr_q[dram_msb:dram_lsb], hdr_owner, 2'b00,
			          hdr_q[owner_lsb-3:0]};
	end

	////////////////////////////////////////////////////////////
	// header decode FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			state    <= disp_idle;
			pay_len  <= '0;
			move_cnt <= '0;
			cmd_sent <= 1'b0;
		end else begin
			case (state)
				disp_idle: begin
					if (!in_empty)
						state <= disp_decode;
				end
				disp_decode: begin
					move_cnt <= '0;
					cmd_sent <= 1'b0;
					pay_len  <= (hdr_len == '0) ? '0 : hdr_len - 1'b1;
					case (msg_form_e'(hdr_q[form_msb:form_lsb]))
						msg_read:  state <= disp_read_out;
						msg_write: state <= disp_write_move;
						default:   state <= disp_idle;       // unknown form dropped
					endcase
				end
				disp_read_out: begin
					if (rcc_ready)
						state <= disp_idle;
				end
				disp_write_move: begin
					if (cmd_push_w)
						cmd_sent <= 1'b1;
					if (data_move)
						move_cnt <= move_cnt + 1'b1;
					if (cmd_sent && move_cnt == pay_len)
						state <= disp_idle;
				end
				default: state <= disp_idle;
			endcase
		end
	end

endmodule

// File: verilog/write_stream_engine.sv
`timescale 1ns/10ps

module write_stream_engine import dma_path_pkg::*; (
	input  logic                    fpu_clk,
	input  logic                    reset,
	write_path_if.consumer          wpath,
	output logic [dram_addr_w-1:0]  wcc_dram_addr,
	output logic [dpram_addr_w-1:0] wcc_dpram_addr,
	output logic [len_w-1:0]        wcc_length,
	output logic [beat_w-1:0]       wcc_write_data,
	output logic                    wcc_valid,
	input  logic                    wcc_ready
);

	wr_state_e         state;
	logic              cmd_pop;
	logic              cmd_full;
	logic              cmd_empty;
	logic [cmd_w-1:0]  cmd_rdata;
	logic [cmd_w-1:0]  cmd_q;
	logic              data_pop;
	logic              data_full;
	logic              data_empty;
	logic [beat_w-1:0] data_rdata;
	logic [len_w-1:0]  head_len;
	logic [len_w-1:0]  pay_len;
	logic [len_w-1:0]  sent_cnt;
	logic              load;

	sync_fifo #(.width(cmd_w), .depth(cmd_depth)) cmd_fifo (
		.fpu_clk (fpu_clk),
		.reset   (reset),
		.push    (wpath.cmd_push),
		.wdata   (wpath.cmd),
		.pop     (cmd_pop),
		.rdata   (cmd_rdata),
		.full    (cmd_full),
		.empty   (cmd_empty)
	);

	sync_fifo #(.width(beat_w), .depth(wdata_depth)) data_fifo (
		.fpu_clk (fpu_clk),
		.reset   (reset),
		.push    (wpath.data_push),
		.wdata   (wpath.data),
		.pop     (data_pop),
		.rdata   (data_rdata),
		.full    (data_full),
		.empty   (data_empty)
	);

	assign wpath.cmd_full  = cmd_full;
	assign wpath.data_full = data_full;

	// a header-only write needs no payload to start
	assign head_len = cmd_rdata[len_msb:len_lsb];
	assign load     = (state == wr_idle) && !cmd_empty && (!data_empty || head_len <= 16'd1);
	assign cmd_pop  = load;

	assign wcc_valid      = (state == wr_stream) && (sent_cnt != pay_len) && !data_empty;
	assign data_pop       = wcc_valid && wcc_ready;   // one beat per accepted cycle
	assign wcc_write_data = data_rdata;
	assign wcc_length     = cmd_q[len_msb:len_lsb];
	assign wcc_dram_addr  = cmd_q[dram_msb:dram_lsb];
	assign wcc_dpram_addr = cmd_q[dpram_addr_w-1:0];

	always_ff @(posedge fpu_clk) begin
		if (load)
			cmd_q <= cmd_rdata;    // fields hold for the burst
	end

	////////////////////////////////////////////////////////////
	// burst streamer
	////////////////////////////////////////////////////////////
	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			state    <= wr_idle;
			pay_len  <= '0;
			sent_cnt <= '0;
		end else begin
			case (state)
				wr_idle: begin
					if (load) begin
						pay_len  <= (head_len == '0) ? '0 : head_len - 1'b1;
						sent_cnt <= '0;
						state    <= wr_stream;
					end
				end
				wr_stream: begin
					if (data_pop)
						sent_cnt <= sent_cnt + 1'b1;
					if (sent_cnt == pay_len || (data_pop && sent_cnt + 1'b1 == pay_len))
						state <= wr_idle;
				end
				default: state <= wr_idle;
			endcase
		end
	end

endmodule

// File: verilog/dma_path_controller.sv
`timescale 1ns/10ps

module dma_path_controller import dma_path_pkg::*; (
	input  logic                    fpu_clk,
	input  logic                    reset,

	// fpu requesters a to d
	input  logic                    dma_req_a,
	output logic                    dma_resp_a,
	input  logic                    dma_write_valid_a,
	input  logic [beat_w-1:0]       dma_write_data_a,
	output logic                    dma_write_ready_a,
	input  logic                    dma_req_b,
	output logic                    dma_resp_b,
	input  logic                    dma_write_valid_b,
	input  logic [beat_w-1:0]       dma_write_data_b,
	output logic                    dma_write_ready_b,
	input  logic                    dma_req_c,
	output logic                    dma_resp_c,
	input  logic                    dma_write_valid_c,
	input  logic [beat_w-1:0]       dma_write_data_c,
	output logic                    dma_write_ready_c,
	input  logic                    dma_req_d,
	output logic                    dma_resp_d,
	input  logic                    dma_write_valid_d,
	input  logic [beat_w-1:0]       dma_write_data_d,
	output logic                    dma_write_ready_d,

	// read command toward the risc dma block
	output logic [dram_addr_w-1:0]  rcc_dram_addr,
	output logic [dpram_addr_w-1:0] rcc_dpram_addr,
	output logic [len_w-1:0]        rcc_length,
	output logic                    rcc_valid,
	input  logic                    rcc_ready,

	// write command and payload
	output logic [dram_addr_w-1:0]  wcc_dram_addr,
	output logic [dpram_addr_w-1:0] wcc_dpram_addr,
	output logic [len_w-1:0]        wcc_length,
	output logic [beat_w-1:0]       wcc_write_data,
	output logic                    wcc_valid,
	input  logic                    wcc_ready
);

	logic [num_ports-1:0] req_vec;
	logic [num_ports-1:0] wvalid_vec;
	logic [num_ports-1:0] resp_vec;
	logic [num_ports-1:0] wready_vec;
	logic [beat_w-1:0]    wdata_arr [num_ports];

	ingress_if    ingress ();
	write_path_if wpath ();

	// port index 0 is requester a
	assign req_vec    = {dma_req_d, dma_req_c, dma_req_b, dma_req_a};
	assign wvalid_vec = {dma_write_valid_d, dma_write_valid_c, dma_write_valid_b,
	                     dma_write_valid_a};
	assign wdata_arr[0] = dma_write_data_a;
	assign wdata_arr[1] = dma_write_data_b;
	assign wdata_arr[2] = dma_write_data_c;
	assign wdata_arr[3] = dma_write_data_d;

	assign {dma_resp_d, dma_resp_c, dma_resp_b, dma_resp_a} = resp_vec;
	assign {dma_write_ready_d, dma_write_ready_c, dma_write_ready_b,
	        dma_write_ready_a} = wready_vec;

	fpu_token_arbiter fpu_token_arbiter_inst (
		.fpu_clk         (fpu_clk),
		.reset           (reset),
		.dma_req         (req_vec),
		.dma_write_valid (wvalid_vec),
		.dma_write_data  (wdata_arr),
		.dma_resp        (resp_vec),
		.dma_write_ready (wready_vec),
		.ingress         (ingress.source)
	);

	dma_command_dispatcher dma_command_dispatcher_inst (
		.fpu_clk        (fpu_clk),
		.reset          (reset),
		.ingress        (ingress.sink),
		.wpath          (wpath.producer),
		.rcc_dram_addr  (rcc_dram_addr),
		.rcc_dpram_addr (rcc_dpram_addr),
		.rcc_length     (rcc_length),
		.rcc_valid      (rcc_valid),
		.rcc_ready      (rcc_ready)
	);

	write_stream_engine write_stream_engine_inst (
		.fpu_clk        (fpu_clk),
		.reset          (reset),
		.wpath          (wpath.consumer),
		.wcc_dram_addr  (wcc_dram_addr),
		.wcc_dpram_addr (wcc_dpram_addr),
		.wcc_length     (wcc_length),
		.wcc_write_data (wcc_write_data),
		.wcc_valid      (wcc_valid),
		.wcc_ready      (wcc_ready)
	);

endmodule

// File: bench/dma_path_checker.sv
`timescale 1ns/10ps

module dma_path_checker import dma_path_pkg::*; (
	input logic        fpu_clk,
	input logic        reset,
	input logic        idle_check,
	input logic [3:0]  req,
	input logic [3:0]  resp,
	input logic [3:0]  wready,
	input logic [39:0] rcc_dram_addr,
	input logic [15:0] rcc_dpram_addr,
	input logic [15:0] rcc_length,
	input logic        rcc_valid,
	input logic        rcc_ready,
	input logic [39:0] wcc_dram_addr,
	input logic [15:0] wcc_dpram_addr,
	input logic [15:0] wcc_length,
	input logic [127:0] wcc_write_data,
	input logic        wcc_valid,
	input logic        wcc_ready
);

	int           errors = 0;
	int           idle_errors = 0;
	int           tests_total = 0;
	int           tests_done = 0;
	logic [87:0]  rd_q [num_ports][$];   // {test, length, dram, dpram}
	logic [87:0]  wr_q [num_ports][$];
	logic [127:0] data_q [num_ports][$];
	logic         form_q [num_ports][$]; // 1 marks a write, in issue order
	int           rd_order [$];          // read owners in grant order
	int           wr_order [$];
	logic [87:0]  cur;
	logic         in_burst = 1'b0;
	int           beats_seen;
	int           burst_errs;
	logic [1:0]   last_owner = 2'd3;     // scan begins at a
	logic [3:0]   owner_vec = 4'b0000;
	logic [3:0]   req_d1 = 4'b0000;
	logic [3:0]   req_d2 = 4'b0000;

	task automatic expect_transfer(input int k, input int p, input logic [7:0] form,
	                               input logic [15:0] len, input logic [39:0] dram,
	                               input logic [15:0] dpram);
		logic [15:0] dp;
		dp = {2'(p), 2'b00, dpram[11:0]};  // owner in 15:14, 13:12 cleared
		tests_total++;
		form_q[p].push_back(form != 8'h01);
		if (form == 8'h01)
			rd_q[p].push_back({16'(k), len, dram, dp});
		else
			wr_q[p].push_back({16'(k), len, dram, dp});
	endtask

	task automatic expect_beat(input int p, input logic [127:0] beat);
		data_q[p].push_back(beat);
	endtask

	task automatic compare(input string name, input logic [127:0] exp, input logic [127:0] act);
		if (exp !== act) begin
			errors++;
			$display("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	// round-robin pick from the request vector
	function automatic logic [1:0] next_owner(input logic [1:0] last, input logic [3:0] r);
		logic [1:0] idx;
		next_owner = last;
		for (int i = 4; i >= 1; i--) begin
			idx = 2'(last + i);
			if (r[idx])
				next_owner = idx;
		end
	endfunction

	task automatic check_read();
		int        own;
		int        e0;
		int        exp_own;
		logic [87:0] e;
		own = rcc_dpram_addr[15:14];
		if (rd_q[own].size() == 0) begin
			errors++;
			$display("ERROR at %0t: read command for requester %0d that was never issued",
			         $time, own);
		end else begin
			e  = rd_q[own].pop_front();
			e0 = errors;
			exp_own = -1;
			if (rd_order.size() != 0)
				exp_own = rd_order.pop_front();
			compare("rcc_dpram_addr[15:14]", 128'(exp_own), 128'(own));  // grant order
			compare("rcc_length", e[71:56], rcc_length);
			compare("rcc_dram_addr", e[55:16], rcc_dram_addr);
			compare("rcc_dpram_addr", e[15:0], rcc_dpram_addr);
			tests_done++;
			$display("test %0d read  requester %0d: %s", e[87:72], own,
			         (errors == e0) ? "ok" : "failed");
		end
	endtask

	task automatic check_write_beat();
		int own;
		int exp_own;
		own = wcc_dpram_addr[15:14];
		if (!in_burst) begin
			if (wr_q[own].size() == 0) begin
				errors++;
				$display("ERROR at %0t: write burst for requester %0d that was never issued",
				         $time, own);
				return;
			end
			cur        = wr_q[own].pop_front();
			burst_errs = errors;
			beats_seen = 0;
			in_burst   = 1'b1;
			exp_own    = -1;
			if (wr_order.size() != 0)
				exp_own = wr_order.pop_front();
			compare("wcc_dpram_addr[15:14]", 128'(exp_own), 128'(own));  // grant order
		end
		// fields hold for the whole burst
		compare("wcc_length", cur[71:56], wcc_length);
		compare("wcc_dram_addr", cur[55:16], wcc_dram_addr);
		compare("wcc_dpram_addr", cur[15:0], wcc_dpram_addr);
		if (data_q[own].size() == 0) begin
			errors++;
			$display("ERROR at %0t: extra payload beat from requester %0d", $time, own);
		end else begin
			compare("wcc_write_data", data_q[own].pop_front(), wcc_write_data);
		end
		beats_seen++;
		if (beats_seen == cur[71:56] - 1) begin
			in_burst = 1'b0;
			tests_done++;
			$display("test %0d write requester %0d, %0d beats: %s", cur[87:72], own,
			         beats_seen, (errors == burst_errs) ? "ok" : "failed");
		end
	endtask

	task automatic check_grant();
		logic [1:0] exp;
		if (resp != 4'b0000) begin
			if (!$onehot(resp)) begin
				errors++;
				$display("ERROR at %0t: response pulse on more than one port", $time);
			end else begin
				exp = next_owner(last_owner, req_d2);   // requests seen by the scan
				compare("dma_resp", 128'(4'b0001 << exp), 128'(resp));
				for (int i = 0; i < 4; i++)
					if (resp[i])
						last_owner = 2'(i);
				owner_vec = resp;
				// outputs must follow the grant order
				if (form_q[last_owner].size() != 0) begin
					if (form_q[last_owner].pop_front())
						wr_order.push_back(last_owner);
					else
						rd_order.push_back(last_owner);
				end
			end
		end
		if ((wready & ~owner_vec) != 4'b0000) begin
			errors++;
			$display("ERROR at %0t: write ready raised on a port without the grant", $time);
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge fpu_clk) begin
		if (!reset) begin
			if (idle_check && (resp != 0 || wready != 0 || rcc_valid || wcc_valid)) begin
				errors++;
				idle_errors++;
				$display("ERROR at %0t: output active with no request pending", $time);
			end
			if (rcc_valid && rcc_ready)
				check_read();
			if (wcc_valid && wcc_ready)
				check_write_beat();
			check_grant();
		end
		req_d2 <= req_d1;
		req_d1 <= req;
	end

	task automatic report_idle();
		$display("test idle: %s", (idle_errors == 0) ? "ok" : "failed");
	endtask

	task automatic report();
		$display("done %0d of %0d transfers, %0d errors", tests_done, tests_total, errors);
	endtask

endmodule

// File: bench/dma_path_properties.sv
`timescale 1ns/10ps

module dma_path_properties (
	input logic         fpu_clk,
	input logic         reset,
	input logic         rcc_valid,
	input logic         rcc_ready,
	input logic [71:0]  rcc_fields,
	input logic         wcc_valid,
	input logic         wcc_ready,
	input logic [199:0] wcc_fields,
	input logic         cmd_push,
	input logic         cmd_full,
	input logic         data_push,
	input logic         data_full,
	input logic [3:0]   grant_vec
);

	int fail_count = 0;

	// read command held while stalled
	rcc_hold_check: assert property (@(posedge fpu_clk) disable iff (reset)
		rcc_valid && !rcc_ready |=> rcc_valid && $stable(rcc_fields))
		else begin
			$error("read command changed or dropped valid while stalled");
			fail_count++;
		end

	// write beat and fields held while stalled
	wcc_hold_check: assert property (@(posedge fpu_clk) disable iff (reset)
		wcc_valid && !wcc_ready |=> wcc_valid && $stable(wcc_fields))
		else begin
			$error("write output changed or dropped valid while stalled");
			fail_count++;
		end

	cmd_push_check: assert property (@(posedge fpu_clk) disable iff (reset)
		cmd_push |-> !cmd_full)
		else begin
			$error("push into a full command buffer");
			fail_count++;
		end

	data_push_check: assert property (@(posedge fpu_clk) disable iff (reset)
		data_push |-> !data_full)
		else begin
			$error("push into a full write data buffer");
			fail_count++;
		end

	grant_check: assert property (@(posedge fpu_clk) disable iff (reset) $onehot0(grant_vec))
		else begin
			$error("grant is not one-hot");
			fail_count++;
		end

endmodule

bind dma_path_controller dma_path_properties path_props (
	.fpu_clk    (fpu_clk),
	.reset      (reset),
	.rcc_valid  (rcc_valid),
	.rcc_ready  (rcc_ready),
	.rcc_fields ({rcc_dram_addr, rcc_dpram_addr, rcc_length}),
	.wcc_valid  (wcc_valid),
	.wcc_ready  (wcc_ready),
	.wcc_fields ({wcc_dram_addr, wcc_dpram_addr, wcc_length, wcc_write_data}),
	.cmd_push   (wpath.cmd_push),
	.cmd_full   (wpath.cmd_full),
	.data_push  (wpath.data_push),
	.data_full  (wpath.data_full),
	.grant_vec  (fpu_token_arbiter_inst.grant)
);

// File: bench/tb_dma_path.sv
`timescale 1ns/10ps

module fpu_clock_gen (
	output logic fpu_clk
);
	initial fpu_clk = 1'b0;
	always #5 fpu_clk = ~fpu_clk;    // 10 ns period
endmodule

module tb_dma_path import dma_path_pkg::*; ();

	logic         fpu_clk;
	logic         reset;
	logic         idle_check;
	logic [3:0]   req_vec;
	logic [3:0]   wvalid_vec;
	logic [127:0] wdata_arr [4];
	logic [3:0]   resp_vec;
	logic [3:0]   wready_vec;
	logic [39:0]  rcc_dram_addr;
	logic [15:0]  rcc_dpram_addr;
	logic [15:0]  rcc_length;
	logic         rcc_valid;
	logic         rcc_ready;
	logic [39:0]  wcc_dram_addr;
	logic [15:0]  wcc_dpram_addr;
	logic [15:0]  wcc_length;
	logic [127:0] wcc_write_data;
	logic         wcc_valid;
	logic         wcc_ready;
	int           seed;
	int           num_pats = 0;
	int           max_len = 0;
	bit           file_ok = 1'b0;
	real          timeout_ns = 0.0;
	int           assert_fails;
	int           pat_port [64];
	logic [7:0]   pat_form [64];
	logic [15:0]  pat_len [64];
	logic [39:0]  pat_dram [64];
	logic [15:0]  pat_dpram [64];

	fpu_clock_gen clk_gen (.fpu_clk(fpu_clk));

	dma_path_controller dma_path_controller_inst (
		.fpu_clk (fpu_clk), .reset (reset),
		.dma_req_a (req_vec[0]), .dma_resp_a (resp_vec[0]),
		.dma_write_valid_a (wvalid_vec[0]), .dma_write_data_a (wdata_arr[0]),
		.dma_write_ready_a (wready_vec[0]),
		.dma_req_b (req_vec[1]), .dma_resp_b (resp_vec[1]),
		.dma_write_valid_b (wvalid_vec[1]), .dma_write_data_b (wdata_arr[1]),
		.dma_write_ready_b (wready_vec[1]),
		.dma_req_c (req_vec[2]), .dma_resp_c (resp_vec[2]),
		.dma_write_valid_c (wvalid_vec[2]), .dma_write_data_c (wdata_arr[2]),
		.dma_write_ready_c (wready_vec[2]),
		.dma_req_d (req_vec[3]), .dma_resp_d (resp_vec[3]),
		.dma_write_valid_d (wvalid_vec[3]), .dma_write_data_d (wdata_arr[3]),
		.dma_write_ready_d (wready_vec[3]),
		.rcc_dram_addr (rcc_dram_addr), .rcc_dpram_addr (rcc_dpram_addr),
		.rcc_length (rcc_length), .rcc_valid (rcc_valid), .rcc_ready (rcc_ready),
		.wcc_dram_addr (wcc_dram_addr), .wcc_dpram_addr (wcc_dpram_addr),
		.wcc_length (wcc_length), .wcc_write_data (wcc_write_data),
		.wcc_valid (wcc_valid), .wcc_ready (wcc_ready)
	);

	dma_path_checker checker_inst (
		.fpu_clk (fpu_clk), .reset (reset), .idle_check (idle_check),
		.req (req_vec), .resp (resp_vec), .wready (wready_vec),
		.rcc_dram_addr (rcc_dram_addr), .rcc_dpram_addr (rcc_dpram_addr),
		.rcc_length (rcc_length), .rcc_valid (rcc_valid), .rcc_ready (rcc_ready),
		.wcc_dram_addr (wcc_dram_addr), .wcc_dpram_addr (wcc_dpram_addr),
		.wcc_length (wcc_length), .wcc_write_data (wcc_write_data),
		.wcc_valid (wcc_valid), .wcc_ready (wcc_ready)
	);

	task automatic load_patterns();
		int          fd;
		int          p;
		int          f;
		int          l;
		logic [39:0] dr;
		logic [15:0] dp;
		string       line;
		fd = $fopen("bench/dma_patterns.txt", "r");
		if (fd == 0) begin
			$display("ERROR: cannot open bench/dma_patterns.txt");
			return;
		end
		while (!$feof(fd) && num_pats < 64) begin
			line = "";
			if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#") begin
				if ($sscanf(line, "%h %h %h %h %h", p, f, l, dr, dp) == 5) begin
					pat_port[num_pats]  = p;
					pat_form[num_pats]  = f;
					pat_len[num_pats]   = l;
					pat_dram[num_pats]  = dr;
					pat_dpram[num_pats] = dp;
					if (l > max_len)
						max_len = l;
					num_pats++;
				end
			end
		end
		$fclose(fd);
		file_ok = (num_pats > 0);
	endtask

	// one beat, held until the port shows ready
	task automatic push_beat(input int p, input logic [127:0] b);
		@(posedge fpu_clk);
		req_vec[p]    <= 1'b0;
		wvalid_vec[p] <= 1'b1;
		wdata_arr[p]  <= b;
		do @(negedge fpu_clk); while (!wready_vec[p]);
	endtask

	task automatic send_transfer(input int k);
		int           p;
		logic [127:0] beat;
		p    = pat_port[k];
		beat = '0;
		beat[79:72] = pat_form[k];
		beat[71:56] = pat_len[k];
		beat[55:16] = pat_dram[k];
		beat[15:0]  = pat_dpram[k];
		checker_inst.expect_transfer(k, p, pat_form[k], pat_len[k], pat_dram[k], pat_dpram[k]);
		@(posedge fpu_clk);
		req_vec[p] <= 1'b1;
		do @(negedge fpu_clk); while (!resp_vec[p]);
		push_beat(p, beat);
		if (pat_form[k] == 8'h03) begin
			for (int i = 1; i < pat_len[k]; i++) begin
				beat = {$random(seed), $random(seed), $random(seed), $random(seed)};
				checker_inst.expect_beat(p, beat);
				push_beat(p, beat);
			end
		end
		@(posedge fpu_clk);
		wvalid_vec[p] <= 1'b0;
	endtask

	task automatic drive_port(input int p);
		for (int k = 0; k < num_pats; k++)
			if (pat_port[k] == p)
				send_transfer(k);
	endtask

	// random back-pressure on both outputs
	always @(posedge fpu_clk) begin
		if (!reset) begin
			rcc_ready <= ($random(seed) & 3) != 0;
			wcc_ready <= ($random(seed) & 3) != 0;
		end
	end

	initial begin
		seed       = 17;
		reset      = 1'b1;
		idle_check = 1'b0;
		req_vec    = '0;
		wvalid_vec = '0;
		rcc_ready  = 1'b1;
		wcc_ready  = 1'b1;
		for (int i = 0; i < 4; i++)
			wdata_arr[i] = '0;
		load_patterns();
		// reset and idle window on top of the per-pattern budget
		timeout_ns = num_pats * (max_len + 40) * 10.0 + 200.0;
		repeat (8) @(posedge fpu_clk);
		reset <= 1'b0;
		if (file_ok) begin
			idle_check <= 1'b1;
			repeat (10) @(posedge fpu_clk);
			idle_check <= 1'b0;
			checker_inst.report_idle();
			fork
				drive_port(0);
				drive_port(1);
				drive_port(2);
				drive_port(3);
			join
			wait (checker_inst.tests_done == checker_inst.tests_total);
			repeat (5) @(posedge fpu_clk);
			checker_inst.report();
		end
		assert_fails = dma_path_controller_inst.path_props.fail_count;
		if (file_ok && checker_inst.errors == 0 && assert_fails == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// watchdog
	initial begin
		wait (timeout_ns > 0.0);
		#(timeout_ns);
		$display("ERROR: watchdog expired at %0t with transfers still outstanding", $time);
		$display("TEST FAIL");
		$finish;
	end

endmodule

// File: project.f
verilog/dma_path_pkg.sv
verilog/dma_path_if.sv
verilog/sync_fifo.sv
verilog/fpu_token_arbiter.sv
verilog/dma_command_dispatcher.sv
verilog/write_stream_engine.sv
verilog/dma_path_controller.sv
bench/dma_path_checker.sv
bench/dma_path_properties.sv
bench/tb_dma_path.sv

// File: Bender.yml
package:
  name: dma_path_controller

sources:
  - files:
      - verilog/dma_path_pkg.sv
      - verilog/dma_path_if.sv
      - verilog/sync_fifo.sv
      - verilog/fpu_token_arbiter.sv
      - verilog/dma_command_dispatcher.sv
      - verilog/write_stream_engine.sv
      - verilog/dma_path_controller.sv
  - target: test
    files:
      - bench/dma_path_checker.sv
      - bench/dma_path_properties.sv
      - bench/tb_dma_path.sv

// File: bench/dma_patterns.txt
# one transfer per line, all fields hex
# requester(0=a..3=d) form length dram_addr dpram_addr
0 03 0004 0000001000 0100
1 03 0004 0000002000 1200
2 03 0004 0000003000 2300
3 03 0004 0000004000 f400
0 01 0010 0000005000 0050
1 03 0008 00000a0000 3000
2 01 0020 0000060000 0a00
3 03 0010 ffffff0000 ffff
0 03 0002 0000007000 0001
1 01 0001 0000008000 c001
2 03 0006 0000009000 0200
3 01 0004 000000b000 0300
